//--- list.f
rtl/vic_timing_pkg.sv
rtl/video_level_pkg.sv
rtl/raster_counter.sv
rtl/vblank_pulses.sv
rtl/color_palette.sv
rtl/sine_rom.sv
rtl/comp_sync.sv
rtl/composite_top.sv
bench/tb_composite.sv

//--- Makefile
# Verilator build and run of the composite video testbench

VERILATOR ?= verilator
TOP       ?= tb_composite
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_composite.sv
`timescale 1ns/1ns
`default_nettype none

module tb_composite;
    import vic_timing_pkg::*;
    import video_level_pkg::*;

    localparam int CLKS = 4;
    localparam int WAIT_LIMIT = 1000000;

    logic       clk_col16x;
    logic       reset;
    chip_t      chip;
    logic [3:0] pixel_color;
    luma_t      blanking_level;
    amp_t       burst_amplitude;
    raster_x_t  raster_x;
    raster_y_t  raster_y;
    luma_t      luma_out;
    logic       luma_sink;
    chroma_t    chroma_out;

    composite_top #(
        .CLKS_PER_X (CLKS)
    ) UUT (
        .clk_col16x      (clk_col16x),
        .reset           (reset),
        .chip            (chip),
        .pixel_color     (pixel_color),
        .blanking_level  (blanking_level),
        .burst_amplitude (burst_amplitude),
        .raster_x        (raster_x),
        .raster_y        (raster_y),
        .luma_out        (luma_out),
        .luma_sink       (luma_sink),
        .chroma_out      (chroma_out)
    );

    initial begin
        clk_col16x = 1'b0;
        forever #50 clk_col16x = ~clk_col16x;
    end

    function automatic int line_len(chip_t c);
        case (c)
            chip_6567r8:   return 520;
            chip_6567r56a: return 512;
            default:       return 504;
        endcase
    endfunction

    function automatic int field_len(chip_t c);
        case (c)
            chip_6567r8:   return 263;
            chip_6567r56a: return 262;
            default:       return 312;
        endcase
    endfunction

    function automatic bit pal_chip(chip_t c);
        return c == chip_6569r1 || c == chip_6569r3;
    endfunction

    function automatic int sync_pos(chip_t c);
        return pal_chip(c) ? 7 : 8;
    endfunction

    // window may wrap past the end of the line
    function automatic bit in_window(int x, int start, int width, int len);
        return ((x - start + 2 * len) % len) < width;
    endfunction

    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
            stop_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    // lands on the first clock of position x, y
    task automatic wait_pos(int x, int y);
        int n;
        n = 0;
        @(negedge clk_col16x);
        while (raster_x != x || raster_y != y) begin
            @(negedge clk_col16x);
            n++;
            if (n > WAIT_LIMIT)
                stop_run($sformatf("timeout waiting for raster x %0d y %0d", x, y));
        end
    endtask

    task automatic reset_dut(chip_t c);
        @(posedge clk_col16x);
        reset <= 1'b1;
        @(posedge clk_col16x);
        chip <= c;
        repeat (3) @(posedge clk_col16x);
        @(negedge clk_col16x);
        check_value("reset luma_sink", 0, luma_sink);
        check_value("reset chroma_out", 32, chroma_out);
        @(posedge clk_col16x);
        reset <= 1'b0;
        @(negedge clk_col16x);
        check_value("reset raster_x", 0, raster_x);
        check_value("reset raster_y", 0, raster_y);
    endtask

    task automatic walk_geometry(chip_t c);
        int max_x;
        int n;
        string name;
        name = $sformatf("geometry %s", c.name());
        reset_dut(c);
        max_x = 0;
        n = 0;
        while (raster_y == 0) begin
            if (raster_x > max_x)
                max_x = raster_x;
            @(negedge clk_col16x);
            n++;
            if (n > WAIT_LIMIT)
                stop_run($sformatf("%s: line 0 never ended", name));
        end
        check_value({name, " last x"}, line_len(c) - 1, max_x);
        wait_pos(0, field_len(c) - 1);
        n = 0;
        while (raster_y == field_len(c) - 1) begin
            @(negedge clk_col16x);
            n++;
            if (n > WAIT_LIMIT)
                stop_run($sformatf("%s: last line never ended", name));
        end
        check_value({name, " y wrap"}, 0, raster_y);
        check_value({name, " x wrap"}, 0, raster_x);
    endtask

    task automatic verify_line_luma(string name, int y, luma_t blank);
        logic [3:0] colour;
        int len;
        int hs;
        int hv;
        int x;
        int exp_luma;
        int exp_sink;
        colour = 4'($urandom % 16);
        len = line_len(chip);
        hs = sync_pos(chip);
        hv = hs + (pal_chip(chip) ? 84 : 88);
        @(posedge clk_col16x);
        pixel_color    <= colour;
        blanking_level <= blank;
        wait_pos(0, y);
        // luma has settled by the last clock of the x
        repeat (CLKS - 1) @(negedge clk_col16x);
        for (x = 0; x < len; x++) begin
            exp_sink = 0;
            if (x >= hs && x < hs + 37) begin
                exp_luma = 0;
                exp_sink = 1;
            end else if (x < hv) begin
                exp_luma = blank;
            end else begin
                exp_luma = palette_luma[colour];
            end
            check_value($sformatf("%s raster_x", name), x, raster_x);
            check_value($sformatf("%s luma x %0d", name, x), exp_luma, luma_out);
            check_value($sformatf("%s sink x %0d", name, x), exp_sink, luma_sink);
            repeat (CLKS) @(negedge clk_col16x);
        end
    endtask

    task automatic scan_vblank(string name);
        int len;
        int hs;
        int half;
        int vbs;
        int i;
        int x;
        int ln;
        bit eq;
        bit se;
        bit pulse;
        len = line_len(chip);
        hs = sync_pos(chip);
        half = len / 2;
        vbs = pal_chip(chip) ? 301 : 14;
        wait_pos(0, vbs);
        repeat (CLKS - 1) @(negedge clk_col16x);
        for (i = 0; i < 9 * len; i++) begin
            x = i % len;
            ln = i / len;
            eq = in_window(x, hs, 18, len) || in_window(x, hs + half, 18, len);
            // broad pulse with a 37 position gap before each half line
            se = !(in_window(x, hs - 37, 37, len) || in_window(x, hs + half - 37, 37, len));
            pulse = (ln >= 3 && ln <= 5) ? se : eq;
            check_value($sformatf("%s raster_y", name), vbs + ln, raster_y);
            check_value($sformatf("%s raster_x", name), x, raster_x);
            check_value($sformatf("%s sink line %0d x %0d", name, ln, x), pulse, luma_sink);
            check_value($sformatf("%s luma line %0d x %0d", name, ln, x),
                        pulse ? 0 : blanking_level, luma_out);
            repeat (CLKS) @(negedge clk_col16x);
        end
    endtask

    task automatic measure_chroma(string name, int y, logic [3:0] colour, amp_t burst);
        int len;
        int hs;
        int hv;
        int bs;
        int i;
        int x;
        int dev;
        int lo;
        int hi;
        int vis_lo;
        int vis_hi;
        amp_t amp;
        len = line_len(chip);
        hs = sync_pos(chip);
        hv = hs + (pal_chip(chip) ? 84 : 88);
        bs = hs + 42;
        amp = palette_amp[colour];
        @(posedge clk_col16x);
        pixel_color     <= colour;
        burst_amplitude <= burst;
        wait_pos(0, y);
        lo = 63;
        hi = 0;
        vis_lo = 63;
        vis_hi = 0;
        // sampled every clock with a few x of margin for the ROM pipeline
        for (i = 0; i < len * CLKS; i++) begin
            x = i / CLKS;
            dev = int'(chroma_out) - 32;
            if (dev < 0)
                dev = -dev;
            check_value($sformatf("%s raster_x", name), x, raster_x);
            if (x >= hs && x < hs + 37) begin
                check_value($sformatf("%s hsync x %0d", name, x), 32, chroma_out);
            end else if (x >= bs + 2 && x < bs + 34) begin
                if (dev > 2 * burst)
                    stop_run($sformatf("%s: burst chroma %0d at x %0d is too far from 32",
                                       name, chroma_out, x));
                if (chroma_out < lo)
                    lo = chroma_out;
                if (chroma_out > hi)
                    hi = chroma_out;
            end else if (x >= hv + 2) begin
                if (amp == 0) begin
                    check_value($sformatf("%s visible x %0d", name, x), 32, chroma_out);
                end else begin
                    if (dev > 2 * amp)
                        stop_run($sformatf("%s: chroma %0d at x %0d exceeds the swing of amplitude %0d",
                                           name, chroma_out, x, amp));
                    if (chroma_out < vis_lo)
                        vis_lo = chroma_out;
                    if (chroma_out > vis_hi)
                        vis_hi = chroma_out;
                end
            end
            @(negedge clk_col16x);
        end
        if (hi == lo)
            stop_run($sformatf("%s: burst chroma stayed at %0d on line %0d", name, lo, y));
        if (amp != 0 && vis_hi == vis_lo)
            stop_run($sformatf("%s: visible chroma stayed at %0d on line %0d",
                               name, vis_lo, y));
    endtask

    initial begin
        logic [3:0] colour;
        void'($urandom(83));
        reset           = 1'b1;
        chip            = chip_6567r8;
        pixel_color     = 4'd0;
        blanking_level  = 6'd16;
        burst_amplitude = 4'd10;

        walk_geometry(chip_6567r8);
        walk_geometry(chip_6567r56a);
        walk_geometry(chip_6569r1);
        walk_geometry(chip_6569r3);

        reset_dut(chip_6567r8);
        verify_line_luma("line luma blank 16", 60, 6'd16);
        verify_line_luma("line luma blank 8", 62, 6'd8);
        scan_vblank("vblank ntsc");

        reset_dut(chip_6569r3);
        scan_vblank("vblank pal");
        measure_chroma("chroma amp zero", 100, 4'($urandom % 2), 4'd10);
        colour = 4'($urandom % 16);
        while (palette_amp[colour] == 0)
            colour = colour + 4'd1;
        measure_chroma("chroma colour", 103, colour, 4'd6);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/composite_top.sv
`timescale 1ns/1ns
`default_nettype none

module composite_top #(
    parameter int CLKS_PER_X = 4
) (
    input  wire logic                      clk_col16x,
    input  wire logic                      reset,
    input  wire vic_timing_pkg::chip_t     chip,
    input  wire logic [3:0]                pixel_color,
    input  wire video_level_pkg::luma_t    blanking_level,
    input  wire video_level_pkg::amp_t     burst_amplitude,
    output vic_timing_pkg::raster_x_t      raster_x,
    output vic_timing_pkg::raster_y_t      raster_y,
    output video_level_pkg::luma_t         luma_out,
    output logic                           luma_sink,
    output video_level_pkg::chroma_t       chroma_out
);
    import video_level_pkg::*;

    logic   x_tick;
    luma_t  luma_level;
    phase_t phase;
    amp_t   amplitude;

    raster_counter #(
        .CLKS_PER_X (CLKS_PER_X)
    ) u_raster_counter (
        .clk_col16x (clk_col16x),
        .reset      (reset),
        .chip       (chip),
        .raster_x   (raster_x),
        .raster_y   (raster_y),
        .x_tick     (x_tick)
    );

    color_palette u_color_palette (
        .clk_col16x  (clk_col16x),
        .reset       (reset),
        .pixel_color (pixel_color),
        .x_tick      (x_tick),
        .luma_level  (luma_level),
        .phase       (phase),
        .amplitude   (amplitude)
    );

    comp_sync u_comp_sync (
        .clk_col16x      (clk_col16x),
        .reset           (reset),
        .chip            (chip),
        .raster_x        (raster_x),
        .raster_y        (raster_y),
        .luma_level      (luma_level),
        .phase           (phase),
        .amplitude       (amplitude),
        .blanking_level  (blanking_level),
        .burst_amplitude (burst_amplitude),
        .luma_out        (luma_out),
        .luma_sink       (luma_sink),
        .chroma_out      (chroma_out)
    );

endmodule

`default_nettype wire

//--- rtl/comp_sync.sv
`timescale 1ns/1ns
`default_nettype none

module comp_sync (
    input  wire logic                      clk_col16x,
    input  wire logic                      reset,
    input  wire vic_timing_pkg::chip_t     chip,
    input  wire vic_timing_pkg::raster_x_t raster_x,
    input  wire vic_timing_pkg::raster_y_t raster_y,
    input  wire video_level_pkg::luma_t    luma_level,
    input  wire video_level_pkg::phase_t   phase,
    input  wire video_level_pkg::amp_t     amplitude,
    input  wire video_level_pkg::luma_t    blanking_level,
    input  wire video_level_pkg::amp_t     burst_amplitude,
    output video_level_pkg::luma_t         luma_out,
    output logic                           luma_sink,
    output video_level_pkg::chroma_t       chroma_out
);
    import vic_timing_pkg::*;
    import video_level_pkg::*;

    logic      eq;
    logic      se;
    raster_y_t line_ofs;
    logic      hblank;
    logic      vblank_area;
    logic      hsync_r;
    logic      vsync_r;
    logic      active_r;
    logic      eq_r;
    logic      se_r;
    logic      eq_line_r;
    logic      se_line_r;
    logic      odd_line_r;

    vblank_pulses u_vblank_pulses (
        .raster_x (raster_x),
        .chip     (chip),
        .eq       (eq),
        .se       (se)
    );

    // line number inside the vertical sync interval
    assign line_ofs    = raster_y - vblank_start(chip);
    assign hblank      = (raster_x - hvisible_end) < (hvisible_start(chip) - hvisible_end);
    assign vblank_area = raster_y >= vvisible_end(chip) && raster_y <= vblank_end(chip);

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            hsync_r    <= 1'b0;
            vsync_r    <= 1'b0;
            active_r   <= 1'b0;
            eq_r       <= 1'b0;
            se_r       <= 1'b0;
            eq_line_r  <= 1'b0;
            se_line_r  <= 1'b0;
            odd_line_r <= 1'b0;
        end else begin
            hsync_r  <= raster_x >= hsync_start(chip) && raster_x < hsync_end(chip);
            vsync_r  <= ((raster_y == vblank_start(chip) && raster_x >= hsync_start(chip)) ||
                         raster_y > vblank_start(chip)) &&
                        (raster_y < vblank_end(chip) ||
                         (raster_y == vblank_end(chip) && raster_x < hsync_end(chip)));
            active_r <= !hblank && !vblank_area;
            eq_r     <= eq;
            se_r     <= se;
            // three equalizing, three serrated, three equalizing lines
            eq_line_r  <= line_ofs <= 9'd2 || (line_ofs >= 9'd6 && line_ofs <= 9'd8);
            se_line_r  <= line_ofs >= 9'd3 && line_ofs <= 9'd5;
            odd_line_r <= raster_y[0];
        end
    end

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            luma_out  <= '0;
            luma_sink <= 1'b0;
        end else if (eq_line_r) begin
            luma_out  <= eq_r ? sync_level : blanking_level;
            luma_sink <= eq_r;
        end else if (se_line_r) begin
            luma_out  <= se_r ? sync_level : blanking_level;
            luma_sink <= se_r;
        end else begin
            luma_out  <= hsync_r ? sync_level : (active_r ? luma_level : blanking_level);
            luma_sink <= hsync_r;
        end
    end

    // colour subcarrier generation
    logic [3:0]  phase_counter;
    raster_y_t   prev_y;
    logic        burst_armed;
    logic        in_burst;
    logic [7:0]  burst_count;
    phase_t      neg_phase;
    phase_t      sel_phase;
    phase_t      wave_phase;
    amp_t        amp_sel;
    amp_t        amp_d1;
    amp_t        amp_d2;
    logic [11:0] rom_addr;
    sine_t       rom_dout;

    assign neg_phase = 8'd0 - phase;

    always_comb begin
        if (active_r)
            sel_phase = (is_pal(chip) && odd_line_r) ? neg_phase : phase;
        else if (is_pal(chip))
            sel_phase = odd_line_r ? 8'd160 : 8'd96;
        else
            sel_phase = 8'd128;
        // 16 samples per subcarrier period
        wave_phase = {phase_counter, 4'b0000} + sel_phase;
        if (vsync_r)
            amp_sel = '0;
        else if (active_r)
            amp_sel = amplitude;
        else if (in_burst)
            amp_sel = burst_amplitude;
        else
            amp_sel = '0;
    end

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            phase_counter <= '0;
            prev_y        <= '0;
            burst_armed   <= 1'b1;
            in_burst      <= 1'b0;
            burst_count   <= '0;
            amp_d1        <= '0;
            amp_d2        <= '0;
            chroma_out    <= chroma_zero;
        end else begin
            phase_counter <= phase_counter + 4'd1;
            prev_y        <= raster_y;
            if (in_burst) begin
                if (burst_count == 8'(burst_samples - 1)) begin
                    in_burst    <= 1'b0;
                    burst_count <= '0;
                end else begin
                    burst_count <= burst_count + 8'd1;
                end
            end else if (burst_armed && raster_x >= burst_start(chip)) begin
                in_burst    <= 1'b1;
                burst_armed <= 1'b0;
            end
            // rearm once per line
            if (raster_y != prev_y)
                burst_armed <= 1'b1;
            // amplitude follows the address and then the ROM data
            amp_d1     <= amp_sel;
            amp_d2     <= amp_d1;
            chroma_out <= (amp_d2 == '0) ? chroma_zero : rom_dout[8:3];
        end
    end

    always_ff @(posedge clk_col16x) begin
        rom_addr <= {amp_sel, wave_phase};
    end

    sine_rom u_sine_rom (
        .clk_col16x (clk_col16x),
        .addr       (rom_addr),
        .dout       (rom_dout)
    );

endmodule

`default_nettype wire

//--- rtl/sine_rom.sv
`timescale 1ns/1ns
`default_nettype none

module sine_rom (
    input  wire logic               clk_col16x,
    input  wire logic [11:0]        addr,
    output video_level_pkg::sine_t  dout
);
    import video_level_pkg::*;

    sine_t rom [4096];

    // offset of 256 keeps every sample positive
    function automatic logic [8:0] sine_entry(input int amp, input int ph);
        real angle;
        real level;
        angle = 2.0 * 3.14159265358979 * real'(ph) / 256.0;
        level = 256.0 + real'(amp) * 15.0 * $sin(angle);
        return 9'($rtoi(level + 0.5));
    endfunction

    // upper address nibble selects amplitude, lower byte the phase
    initial begin
        for (int i = 0; i < 4096; i++) begin
            rom[i] = sine_entry(i / 256, i % 256);
        end
    end

    always_ff @(posedge clk_col16x) begin
        dout <= rom[addr];
    end

endmodule

`default_nettype wire

//--- rtl/color_palette.sv
`timescale 1ns/1ns
`default_nettype none

module color_palette (
    input  wire logic                  clk_col16x,
    input  wire logic                  reset,
    input  wire logic [3:0]            pixel_color,
    input  wire logic                  x_tick,
    output video_level_pkg::luma_t     luma_level,
    output video_level_pkg::phase_t    phase,
    output video_level_pkg::amp_t      amplitude
);
    import video_level_pkg::*;

    // values change together with raster_x
    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            luma_level <= '0;
            phase      <= '0;
            amplitude  <= '0;
        end else if (x_tick) begin
            luma_level <= palette_luma[pixel_color];
            phase      <= palette_phase[pixel_color];
            amplitude  <= palette_amp[pixel_color];
        end
    end

endmodule

`default_nettype wire

//--- rtl/vblank_pulses.sv
`timescale 1ns/1ns
`default_nettype none

module vblank_pulses (
    input  wire vic_timing_pkg::raster_x_t raster_x,
    input  wire vic_timing_pkg::chip_t     chip,
    output logic                           eq,
    output logic                           se
);
    import vic_timing_pkg::*;

    raster_x_t line_len;
    raster_x_t half_line;
    raster_x_t start;
    raster_x_t rel;
    raster_x_t half_rel;

    always_comb begin
        line_len  = line_length(chip);
        half_line = line_len >> 1;
        start     = hsync_start(chip);

        // positions before hsync start still belong to the
        // second half of the previous line
        if (raster_x >= start)
            rel = raster_x - start;
        else
            rel = raster_x + line_len - start;

        // fold onto a single half line
        half_rel = (rel >= half_line) ? rel - half_line : rel;

        // narrow 18 position pulse twice a line
        eq = half_rel < 10'd18;
        // broad pulse that drops for 37 positions before the next half
        se = half_rel < half_line - 10'd37;
    end

endmodule

`default_nettype wire

//--- rtl/raster_counter.sv
`timescale 1ns/1ns
`default_nettype none

module raster_counter #(
    parameter int CLKS_PER_X = 4
) (
    input  wire logic                      clk_col16x,
    input  wire logic                      reset,
    input  wire vic_timing_pkg::chip_t     chip,
    output vic_timing_pkg::raster_x_t      raster_x,
    output vic_timing_pkg::raster_y_t      raster_y,
    output logic                           x_tick
);
    import vic_timing_pkg::*;

    localparam int DIV_W = (CLKS_PER_X > 1) ? $clog2(CLKS_PER_X) : 1;

    logic [DIV_W-1:0] div;

    // last clock of the current x position
    assign x_tick = (div == DIV_W'(CLKS_PER_X - 1));

    always_ff @(posedge clk_col16x) begin
        if (reset) begin
            div      <= '0;
            raster_x <= '0;
            raster_y <= '0;
        end else if (x_tick) begin
            div <= '0;
            if (raster_x == line_length(chip) - 10'd1) begin
                raster_x <= '0;
                // next line wraps at the end of the field
                if (raster_y == field_lines(chip) - 9'd1)
                    raster_y <= '0;
                else
                    raster_y <= raster_y + 9'd1;
            end else begin
                raster_x <= raster_x + 10'd1;
            end
        end else begin
            div <= div + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/video_level_pkg.sv
`default_nettype none

package video_level_pkg;

    typedef logic [5:0] luma_t;
    typedef logic [5:0] chroma_t;
    // 256 steps per colour cycle
    typedef logic [7:0] phase_t;
    typedef logic [3:0] amp_t;
    typedef logic [8:0] sine_t;

    localparam chroma_t chroma_zero = 6'd32;
    localparam luma_t sync_level = 6'd0;

    // 16 samples per colour clock period
    localparam int burst_periods = 9;
    localparam int burst_samples = burst_periods * 16;

    // black, white, red, cyan, purple, green, blue, yellow,
    // orange, brown, light red, dark grey, grey, light green, light blue, light grey
    localparam luma_t palette_luma [16] = '{
        6'd12, 6'd63, 6'd24, 6'd42, 6'd30, 6'd36, 6'd21, 6'd49,
        6'd30, 6'd21, 6'd36, 6'd24, 6'd35, 6'd49, 6'd35, 6'd42
    };
    localparam phase_t palette_phase [16] = '{
        8'd0,   8'd0,   8'd80,  8'd208, 8'd32,  8'd160, 8'd0,   8'd128,
        8'd96,  8'd112, 8'd80,  8'd0,   8'd0,   8'd160, 8'd0,   8'd0
    };
    localparam amp_t palette_amp [16] = '{
        4'd0,  4'd0,  4'd13, 4'd10, 4'd12, 4'd11, 4'd10, 4'd14,
        4'd14, 4'd14, 4'd13, 4'd0,  4'd0,  4'd11, 4'd10, 4'd0
    };

endpackage

`default_nettype wire

//--- rtl/vic_timing_pkg.sv
`default_nettype none

package vic_timing_pkg;

    // bit 0 set on the PAL parts
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6569r3   = 2'd1,
        chip_6567r56a = 2'd2,
        chip_6569r1   = 2'd3
    } chip_t;

    typedef logic [9:0] raster_x_t;
    typedef logic [8:0] raster_y_t;

    // visible picture ends where the line starts
    localparam raster_x_t hvisible_end = 10'd0;

    function automatic logic is_pal(chip_t chip);
        return chip == chip_6569r1 || chip == chip_6569r3;
    endfunction

    function automatic raster_x_t line_length(chip_t chip);
        case (chip)
            chip_6567r8:   return 10'd520;
            chip_6567r56a: return 10'd512;
            default:       return 10'd504;
        endcase
    endfunction

    function automatic raster_y_t field_lines(chip_t chip);
        case (chip)
            chip_6567r8:   return 9'd263;
            chip_6567r56a: return 9'd262;
            default:       return 9'd312;
        endcase
    endfunction

    function automatic raster_x_t hsync_start(chip_t chip);
        return is_pal(chip) ? 10'd7 : 10'd8;
    endfunction

    // about 4.7us of sync tip
    function automatic raster_x_t hsync_end(chip_t chip);
        return hsync_start(chip) + 10'd37;
    endfunction

    function automatic raster_x_t hvisible_start(chip_t chip);
        return hsync_start(chip) + (is_pal(chip) ? 10'd84 : 10'd88);
    endfunction

    // breezeway after sync before the burst
    function automatic raster_x_t burst_start(chip_t chip);
        return hsync_end(chip) + 10'd5;
    endfunction

    function automatic raster_y_t vblank_start(chip_t chip);
        return is_pal(chip) ? 9'd301 : 9'd14;
    endfunction

    function automatic raster_y_t vblank_end(chip_t chip);
        return vblank_start(chip) + 9'd8;
    endfunction

    function automatic raster_y_t vvisible_end(chip_t chip);
        return vblank_start(chip) - 9'd1;
    endfunction

endpackage

`default_nettype wire
